//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_gnn_layer
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  := Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f compile.f
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
design/gnn_pkg.sv
design/weight_sram.sv
design/weight_cntl.sv
design/feature_buffer.sv
design/vertex_pe.sv
design/gnn_layer_top.sv
testbench/gnn_layer_chk.sv
testbench/tb_gnn_layer.sv

//--- design/feature_buffer.sv
`timescale 1ns/10ps

module feature_buffer (
    input  logic             clk,
    input  logic             reset,
    input  logic             feat_wr_en,
    input  gnn_pkg::fv_idx_t feat_wr_idx,
    input  gnn_pkg::elem_t   feat_wr_data,
    input  gnn_pkg::fv_idx_t fv_idx,
    output gnn_pkg::elem_t   f0,
    output gnn_pkg::elem_t   f1
);
    import gnn_pkg::*;

    elem_t   feat_mem [MAX_FV_NUM];
    fv_idx_t idx_hi;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MAX_FV_NUM; i++) begin
                feat_mem[i] <= '0;
            end
        end else if (feat_wr_en) begin
            feat_mem[feat_wr_idx] <= feat_wr_data;
        end
    end

    // fv_idx is even, so idx_hi never wraps
    assign idx_hi = fv_idx + 1'b1;

    assign f0 = feat_mem[fv_idx];
    assign f1 = feat_mem[idx_hi];

endmodule

//--- design/gnn_layer_top.sv
`timescale 1ns/10ps

module gnn_layer_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                fire,
    input  gnn_pkg::layer_t     num_weight_layer,
    input  gnn_pkg::fv_cnt_t    num_fv,
    input  logic                wr_en,
    input  gnn_pkg::sram_addr_t wr_addr,
    input  gnn_pkg::sram_line_t wr_data,
    input  logic                feat_wr_en,
    input  gnn_pkg::fv_idx_t    feat_wr_idx,
    input  gnn_pkg::elem_t      feat_wr_data,
    output gnn_pkg::acc_t       result,
    output gnn_pkg::layer_t     result_layer,
    output logic                result_valid,
    output logic                done,
    output logic                idle
);
    import gnn_pkg::*;

    // beat stream from the weight path
    elem_t   w0;
    elem_t   w1;
    fv_idx_t fv_idx;
    layer_t  layer;
    logic    beat_valid;
    logic    layer_last;
    logic    eos;

    // feature pair at the beat's index
    elem_t   f0;
    elem_t   f1;

    // start of job is not needed by the element
    weight_cntl u_weight_cntl (
        .clk              (clk),
        .reset            (reset),
        .fire             (fire),
        .num_weight_layer (num_weight_layer),
        .num_fv           (num_fv),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .w0               (w0),
        .w1               (w1),
        .fv_idx           (fv_idx),
        .layer            (layer),
        .beat_valid       (beat_valid),
        .sos              (),
        .layer_last       (layer_last),
        .eos              (eos),
        .idle             (idle)
    );

    feature_buffer u_feature_buffer (
        .clk          (clk),
        .reset        (reset),
        .feat_wr_en   (feat_wr_en),
        .feat_wr_idx  (feat_wr_idx),
        .feat_wr_data (feat_wr_data),
        .fv_idx       (fv_idx),
        .f0           (f0),
        .f1           (f1)
    );

    vertex_pe u_vertex_pe (
        .clk          (clk),
        .reset        (reset),
        .w0           (w0),
        .w1           (w1),
        .f0           (f0),
        .f1           (f1),
        .beat_valid   (beat_valid),
        .layer_last   (layer_last),
        .eos          (eos),
        .layer        (layer),
        .result       (result),
        .result_layer (result_layer),
        .result_valid (result_valid),
        .done         (done)
    );

endmodule

//--- design/gnn_pkg.sv
package gnn_pkg;

    // element and beat geometry
    localparam int FV_SIZE     = 8;
    localparam int MULT_PER_PE = 2;

    // job limits
    localparam int MAX_FV_NUM           = 16;
    localparam int MAX_NUM_WEIGHT_LAYER = 4;

    // weight memory layout, one layer per block of lines
    localparam int LINES_PER_LAYER = MAX_FV_NUM / MULT_PER_PE;
    localparam int SRAM_DEPTH      = MAX_NUM_WEIGHT_LAYER * LINES_PER_LAYER;

    // 16 products of 255 x 255 fit in 20 bits
    localparam int ACC_W = 20;

    // one weight or feature value
    typedef logic [FV_SIZE-1:0] elem_t;

    // element 0 sits in the low byte
    typedef logic [MULT_PER_PE*FV_SIZE-1:0] sram_line_t;

    // {layer, line within layer}
    typedef logic [$clog2(SRAM_DEPTH)-1:0] sram_addr_t;

    typedef logic [$clog2(MAX_NUM_WEIGHT_LAYER)-1:0] layer_t;

    // position in the feature vector
    typedef logic [$clog2(MAX_FV_NUM)-1:0] fv_idx_t;

    // vector length, one bit wider so 16 fits
    typedef logic [$clog2(MAX_FV_NUM):0] fv_cnt_t;

    typedef logic [ACC_W-1:0] acc_t;

endpackage

//--- design/vertex_pe.sv
`timescale 1ns/10ps

module vertex_pe (
    input  logic            clk,
    input  logic            reset,
    input  gnn_pkg::elem_t  w0,
    input  gnn_pkg::elem_t  w1,
    input  gnn_pkg::elem_t  f0,
    input  gnn_pkg::elem_t  f1,
    input  logic            beat_valid,
    input  logic            layer_last,
    input  logic            eos,
    input  gnn_pkg::layer_t layer,
    output gnn_pkg::acc_t   result,
    output gnn_pkg::layer_t result_layer,
    output logic            result_valid,
    output logic            done
);
    import gnn_pkg::*;

    logic [2*FV_SIZE-1:0] prod0;
    logic [2*FV_SIZE-1:0] prod1;
    acc_t                 beat_sum;
    acc_t                 sum_now;
    acc_t                 acc;

    assign prod0    = w0 * f0;
    assign prod1    = w1 * f1;
    assign beat_sum = acc_t'(prod0) + acc_t'(prod1);
    assign sum_now  = acc + beat_sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc          <= '0;
            result_valid <= 1'b0;
            done         <= 1'b0;
        end else begin
            result_valid <= beat_valid && layer_last;
            done         <= beat_valid && eos;
            if (beat_valid) begin
                // layer end starts the next sum from zero
                acc <= layer_last ? '0 : sum_now;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid && layer_last) begin
            result       <= sum_now;
            result_layer <= layer;
        end
    end

endmodule

//--- design/weight_cntl.sv
`timescale 1ns/10ps

module weight_cntl (
    input  logic                clk,
    input  logic                reset,
    input  logic                fire,
    input  gnn_pkg::layer_t     num_weight_layer,
    input  gnn_pkg::fv_cnt_t    num_fv,
    input  logic                wr_en,
    input  gnn_pkg::sram_addr_t wr_addr,
    input  gnn_pkg::sram_line_t wr_data,
    output gnn_pkg::elem_t      w0,
    output gnn_pkg::elem_t      w1,
    output gnn_pkg::fv_idx_t    fv_idx,
    output gnn_pkg::layer_t     layer,
    output logic                beat_valid,
    output logic                sos,
    output logic                layer_last,
    output logic                eos,
    output logic                idle
);
    import gnn_pkg::*;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_WORK = 1'b1
    } state_t;

    state_t     state;
    layer_t     layer_cnt;
    fv_idx_t    pos_cnt;
    fv_cnt_t    pos_next;
    logic       pos_wrap;
    logic       job_end;
    logic       start;
    logic       issue;

    // read in flight, with its framing tags
    logic       rd_en_q;
    sram_addr_t rd_addr_q;
    fv_idx_t    rd_pos_q;
    layer_t     rd_layer_q;
    logic       rd_sos_q;
    logic       rd_last_q;
    logic       rd_eos_q;

    logic       sram_cen;
    logic       sram_wen;
    sram_addr_t sram_addr;
    sram_line_t sram_q;

    // the fire cycle already issues the first read
    assign start    = (state == ST_IDLE) && fire && idle;
    assign issue    = start || (state == ST_WORK);
    assign pos_next = fv_cnt_t'(pos_cnt) + fv_cnt_t'(MULT_PER_PE);
    assign pos_wrap = (pos_next == num_fv);
    assign job_end  = pos_wrap && (layer_cnt == num_weight_layer);

    // counters point at the next line to read
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            layer_cnt <= '0;
            pos_cnt   <= '0;
        end else if (issue) begin
            if (job_end) begin
                state     <= ST_IDLE;
                layer_cnt <= '0;
                pos_cnt   <= '0;
            end else begin
                state <= ST_WORK;
                if (pos_wrap) begin
                    pos_cnt   <= '0;
                    layer_cnt <= layer_cnt + 1'b1;
                end else begin
                    pos_cnt <= fv_idx_t'(pos_next);
                end
            end
        end
    end

    // address register stage
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_en_q   <= 1'b0;
            rd_sos_q  <= 1'b0;
            rd_last_q <= 1'b0;
            rd_eos_q  <= 1'b0;
        end else begin
            rd_en_q   <= issue;
            rd_sos_q  <= start;
            rd_last_q <= issue && pos_wrap;
            rd_eos_q  <= issue && job_end;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr_q  <= {layer_cnt, pos_cnt[$bits(fv_idx_t)-1:1]};
        rd_pos_q   <= pos_cnt;
        rd_layer_q <= layer_cnt;
    end

    // host owns the port whenever no read is pending
    assign sram_cen  = rd_en_q ? 1'b0 : ~wr_en;
    assign sram_wen  = rd_en_q ? 1'b1 : ~wr_en;
    assign sram_addr = rd_en_q ? rd_addr_q : wr_addr;

    weight_sram u_weight_sram (
        .clk  (clk),
        .cen  (sram_cen),
        .wen  (sram_wen),
        .addr (sram_addr),
        .d    (wr_data),
        .q    (sram_q)
    );

    // tags move into the beat as the sram registers its data
    always_ff @(posedge clk) begin
        if (reset) begin
            beat_valid <= 1'b0;
            sos        <= 1'b0;
            layer_last <= 1'b0;
            eos        <= 1'b0;
            idle       <= 1'b1;
        end else begin
            beat_valid <= rd_en_q;
            sos        <= rd_sos_q;
            layer_last <= rd_last_q;
            eos        <= rd_eos_q;
            if (start) begin
                idle <= 1'b0;
            end else if (eos) begin
                idle <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        fv_idx <= rd_pos_q;
        layer  <= rd_layer_q;
    end

    assign w0 = sram_q[FV_SIZE-1:0];
    assign w1 = sram_q[2*FV_SIZE-1:FV_SIZE];

endmodule

//--- design/weight_sram.sv
`timescale 1ns/10ps

module weight_sram (
    input  logic                clk,
    input  logic                cen,
    input  logic                wen,
    input  gnn_pkg::sram_addr_t addr,
    input  gnn_pkg::sram_line_t d,
    output gnn_pkg::sram_line_t q
);
    import gnn_pkg::*;

    sram_line_t mem [SRAM_DEPTH];

    // single port, both enables active low
    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[addr] <= d;
            end else begin
                // read data lands one cycle after the address
                q <= mem[addr];
            end
        end
    end

endmodule

//--- testbench/gnn_layer_chk.sv
`timescale 1ns/10ps

module gnn_layer_chk (
    input logic clk,
    input logic reset,
    input logic fire,
    input logic idle,
    input logic beat_valid,
    input logic result_valid,
    input logic done
);

    // done marks the last result of a job
    a_done_has_result: assert property (@(posedge clk) disable iff (reset)
        done |-> result_valid)
        else $error("done asserted without result_valid");

    // a fire while busy starts no new beat stream once the job has ended
    a_fire_busy_ignored: assert property (@(posedge clk) disable iff (reset)
        fire && !idle |-> ##2 !(idle && beat_valid))
        else $error("fire while busy started a new job");

    a_fire_starts_job: assert property (@(posedge clk) disable iff (reset)
        fire && idle |=> !idle)
        else $error("idle stayed high after an accepted fire");

    // idle only comes back with the final result
    a_idle_until_done: assert property (@(posedge clk) disable iff (reset)
        $rose(idle) |-> done)
        else $error("idle rose before done");

endmodule

bind gnn_layer_top gnn_layer_chk u_chk (.*);

//--- testbench/tb_gnn_layer.sv
`timescale 1ns/10ps

module tb_gnn_layer;
    import gnn_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int JOB_MARGIN   = 50;

    logic       clk;
    logic       reset;
    logic       fire;
    layer_t     num_weight_layer;
    fv_cnt_t    num_fv;
    logic       wr_en;
    sram_addr_t wr_addr;
    sram_line_t wr_data;
    logic       feat_wr_en;
    fv_idx_t    feat_wr_idx;
    elem_t      feat_wr_data;
    acc_t       result;
    layer_t     result_layer;
    logic       result_valid;
    logic       done;
    logic       idle;

    // commands from the stimulus file, in file order
    string      cmd_kind [$];
    string      cmd_name [$];
    int         cmd_a [$];
    int         cmd_b [$];
    int         cmd_c [$];

    // state of the running job
    string      job_name = "reset";
    int         job_errors = 0;
    int         job_latency = 0;
    int         results_seen = 0;
    logic       job_done = 1'b0;
    acc_t       exp_q [$];
    acc_t       exp_val;
    logic       exp_last;

    int         cycle = 0;
    int         fire_cycle = 0;
    int         limit_cycles = 0;
    logic       limit_ready = 1'b0;
    logic       stim_ok;
    int         error_count = 0;
    int         tests_run = 0;
    int         tests_failed = 0;

    gnn_layer_top u_dut (
        .clk              (clk),
        .reset            (reset),
        .fire             (fire),
        .num_weight_layer (num_weight_layer),
        .num_fv           (num_fv),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .feat_wr_en       (feat_wr_en),
        .feat_wr_idx      (feat_wr_idx),
        .feat_wr_data     (feat_wr_data),
        .result           (result),
        .result_layer     (result_layer),
        .result_valid     (result_valid),
        .done             (done),
        .idle             (idle)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic read_stimulus(output logic ok);
        int    fd;
        int    code;
        logic  bad;
        string kind;
        string name;
        string rest;
        int    a;
        int    b;
        int    c;
        ok = 1'b0;
        bad = 1'b0;
        fd = $fopen("testbench/tb_input.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fscanf(fd, " %s", kind) == 1) begin
            a = 0;
            b = 0;
            c = 0;
            name = "";
            code = 1;
            if (kind == "#") begin
                code = $fgets(rest, fd);
            end else if (kind == "W" || kind == "F") begin
                code = $fscanf(fd, " %h %h %h", a, b, c);
            end else if (kind == "J") begin
                code = $fscanf(fd, " %s %d %d", name, a, b);
            end else if (kind == "E") begin
                code = $fscanf(fd, " %d", a);
            end else begin
                $display("unknown command %s in the stimulus file", kind);
                bad = 1'b1;
            end
            if (code <= 0) begin
                $display("stimulus line starting with %s is incomplete", kind);
                bad = 1'b1;
            end
            if (kind != "#") begin
                cmd_kind.push_back(kind);
                cmd_name.push_back(name);
                cmd_a.push_back(a);
                cmd_b.push_back(b);
                cmd_c.push_back(c);
            end
        end
        $fclose(fd);
        ok = !bad;
    endtask

    // inputs change shortly after the rising edge
    task automatic next_drive();
        @(posedge clk);
        #1;
    endtask

    task automatic load_weights(int first, int last, int data);
        for (int addr = first; addr <= last; addr++) begin
            next_drive();
            wr_en   = 1'b1;
            wr_addr = sram_addr_t'(addr);
            wr_data = sram_line_t'(data);
        end
        next_drive();
        wr_en = 1'b0;
    endtask

    task automatic load_features(int first, int last, int value);
        for (int idx = first; idx <= last; idx++) begin
            next_drive();
            feat_wr_en   = 1'b1;
            feat_wr_idx  = fv_idx_t'(idx);
            feat_wr_data = elem_t'(value);
        end
        next_drive();
        feat_wr_en = 1'b0;
    endtask

    task automatic close_test(string name);
        tests_run++;
        if (job_errors == 0) begin
            $display("test %s passed, %0d results", name, results_seen);
        end else begin
            $display("test %s failed with %0d errors", name, job_errors);
            tests_failed++;
        end
        error_count += job_errors;
    endtask

    task automatic run_job(string name, int layers_m1, int fv_len);
        int wait_cycles;
        int budget;
        int beats;
        beats        = (layers_m1 + 1) * fv_len / 2;
        budget       = beats + JOB_MARGIN;
        job_name     = name;
        job_errors   = 0;
        results_seen = 0;
        job_done     = 1'b0;
        job_latency  = fv_len / 2 + 2;
        next_drive();
        num_weight_layer = layer_t'(layers_m1);
        num_fv           = fv_cnt_t'(fv_len);
        fire             = 1'b1;
        fire_cycle       = cycle;
        next_drive();
        fire = 1'b0;
        // fire again just after the last read, while idle is still low
        repeat (beats - 1) next_drive();
        fire = 1'b1;
        next_drive();
        fire = 1'b0;
        wait_cycles = 0;
        while (!(job_done && idle) && wait_cycles < budget) begin
            next_drive();
            wait_cycles++;
        end
        if (!job_done || !idle) begin
            $display("test %s did not finish within %0d cycles", name, budget);
            job_errors++;
        end
        if (exp_q.size() != 0) begin
            $display("test %s is missing %0d results", name, exp_q.size());
            job_errors++;
            exp_q.delete();
        end
        close_test(name);
    endtask

    task automatic check_idle_after_reset();
        job_errors   = 0;
        results_seen = 0;
        repeat (4) next_drive();
        if (idle !== 1'b1) begin
            $display("FAILED reset_idle: expected 1, actual %b", idle);
            job_errors++;
        end
        close_test("reset_idle");
    endtask

    task automatic run_commands();
        int    i;
        string name;
        int    layers_m1;
        int    fv_len;
        i = 0;
        while (i < cmd_kind.size()) begin
            if (cmd_kind[i] == "W") begin
                load_weights(cmd_a[i], cmd_b[i], cmd_c[i]);
            end else if (cmd_kind[i] == "F") begin
                load_features(cmd_a[i], cmd_b[i], cmd_c[i]);
            end else if (cmd_kind[i] == "J") begin
                name      = cmd_name[i];
                layers_m1 = cmd_a[i];
                fv_len    = cmd_b[i];
                // the E lines that follow belong to this job
                while (i + 1 < cmd_kind.size() && cmd_kind[i + 1] == "E") begin
                    i++;
                    exp_q.push_back(acc_t'(cmd_a[i]));
                end
                run_job(name, layers_m1, fv_len);
            end
            i++;
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset && done && !result_valid) begin
            $display("done came without a result in test %s", job_name);
            error_count++;
        end
        if (!reset && result_valid) begin
            if (exp_q.size() == 0) begin
                $display("result %0d of layer %0d arrived while no job expected one",
                         result, result_layer);
                error_count++;
            end else begin
                exp_val  = exp_q.pop_front();
                exp_last = (exp_q.size() == 0);
                if (results_seen == 0 && cycle - fire_cycle != job_latency) begin
                    $display("test %s gave its first result %0d cycles after fire, not %0d",
                             job_name, cycle - fire_cycle, job_latency);
                    job_errors++;
                end
                if (result !== exp_val) begin
                    $display("FAILED %s result %0d: expected %0d, actual %0d",
                             job_name, results_seen, exp_val, result);
                    job_errors++;
                end
                if (result_layer !== layer_t'(results_seen)) begin
                    $display("FAILED %s layer tag: expected %0d, actual %0d",
                             job_name, results_seen, result_layer);
                    job_errors++;
                end
                if (done !== exp_last) begin
                    $display("FAILED %s done on result %0d: expected %b, actual %b",
                             job_name, results_seen, exp_last, done);
                    job_errors++;
                end
                results_seen++;
                if (done) begin
                    job_done = 1'b1;
                end
            end
        end
    end

    initial begin
        reset            = 1'b1;
        fire             = 1'b0;
        num_weight_layer = '0;
        num_fv           = '0;
        wr_en            = 1'b0;
        wr_addr          = '0;
        wr_data          = '0;
        feat_wr_en       = 1'b0;
        feat_wr_idx      = '0;
        feat_wr_data     = '0;
        read_stimulus(stim_ok);
        if (!stim_ok) begin
            $display("stimulus file testbench/tb_input.txt could not be read");
            $display("Simulation failed");
            $finish;
        end else begin
            // reset, loads and every job's beats plus margin
            limit_cycles = RESET_CYCLES + 10;
            for (int i = 0; i < cmd_kind.size(); i++) begin
                if (cmd_kind[i] == "W" || cmd_kind[i] == "F") begin
                    limit_cycles += cmd_b[i] - cmd_a[i] + 2;
                end else if (cmd_kind[i] == "J") begin
                    limit_cycles += (cmd_a[i] + 1) * cmd_b[i] / 2 + JOB_MARGIN;
                end
            end
            limit_ready = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            #1;
            reset = 1'b0;
            check_idle_after_reset();
            run_commands();
            $display("tests run %0d, failed %0d, errors %0d",
                     tests_run, tests_failed, error_count);
            if (error_count == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    initial begin
        wait (limit_ready);
        #(limit_cycles * CLK_PERIOD);
        $display("watchdog stopped the run after %0d clock cycles", limit_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- testbench/tb_input.txt
# W first last data: fill SRAM lines first..last with one word; F first last value: fill features
# W and F fields are hex; J name layers_minus_one num_fv and E expected_result are decimal
W 00 00 0201
W 01 07 0101
W 08 08 0403
W 09 0f 0202
W 10 10 0605
W 11 17 0103
W 18 18 0807
W 19 1f 0504
F 0 0 0a
F 1 1 14
F 2 f 03
J single_layer 0 16
E 92
J four_layers 3 16
E 92
E 194
E 254
E 419
J short_vector 3 2
E 50
E 110
E 170
E 230
W 00 07 ffff
F 0 f ff
J max_value 0 16
E 1040400
J repeat_max 0 16
E 1040400
F 0 f 01
J reloaded_features 1 16
E 4080
E 35
